/* tb.f */
+incdir+verilog
verilog/mips_pkg.sv
verilog/instr_decoder.sv
verilog/register_file.sv
verilog/id_ex_reg.sv
verilog/ex_unit.sv
verilog/id_ex_stage.sv
verification/id_ex_stage_chk.sv
verification/id_ex_stage_tb.sv

/* verification/id_ex_stage_chk.sv */
`timescale 1ns/1ns
`default_nettype none

module id_ex_stage_chk (
    input logic i_clock,
    input logic rst_n,
    input logic reg_write,
    input logic mem_to_reg,
    input logic mem_read,
    input logic mem_write,
    input logic byte_en,
    input logic halfword_en,
    input logic word_en,
    input logic branch_taken
);

    int   fail_count = 0; // Read by the testbench at the end of the run.
    logic any_control;

    assign any_control = reg_write | mem_to_reg | mem_read | mem_write |
                         byte_en | halfword_en | word_en | branch_taken;

    // The first edge after release still shows the bubble left by reset.
    quiet_after_reset: assert property (@(posedge i_clock) $rose(rst_n) |-> !any_control)
        else begin
            $error("control outputs active on the first edge after reset release");
            fail_count++;
        end

    one_size_enable: assert property (@(posedge i_clock) disable iff (!rst_n)
        $onehot0({byte_en, halfword_en, word_en}))
        else begin
            $error("more than one access size enable is high");
            fail_count++;
        end

    load_uses_memory: assert property (@(posedge i_clock) disable iff (!rst_n)
        mem_read |-> mem_to_reg)
        else begin
            $error("mem_read is high without mem_to_reg");
            fail_count++;
        end

    branch_writes_nothing: assert property (@(posedge i_clock) disable iff (!rst_n)
        branch_taken |-> !reg_write && !mem_write)
        else begin
            $error("taken branch also writes a register or memory");
            fail_count++;
        end

endmodule

`default_nettype wire

/* verification/id_ex_stage_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mips_config.svh"

module id_ex_stage_tb
    import mips_pkg::*;
();

    localparam int     NUM_RANDOM    = 300;
    localparam int     RESET_TIMEOUT = 40;
    localparam int     DRAIN_TIMEOUT = 20;
    localparam instr_t BUBBLE        = 32'hffff_ffff; // Opcode 0x3f is not decoded.

    typedef struct packed {
        data_t      alu_result;
        logic       branch_taken;
        pc_t        branch_target;
        reg_addr_t  write_reg;
        data_t      store_data;
        logic [6:0] ctrl; // reg_write, mem_to_reg, mem_read, mem_write, byte, half, word.
        logic       chk_alu;
        logic       chk_target;
        logic       chk_wreg;
        logic       chk_store;
    } expect_t;

    logic      i_clock = 1'b0;
    logic      rst_n = 1'b0;
    instr_t    instr;
    pc_t       pc;
    logic      wb_reg_write;
    reg_addr_t wb_write_reg;
    data_t     wb_write_data;
    data_t     alu_result;
    logic      branch_taken;
    pc_t       branch_target;
    reg_addr_t write_reg;
    data_t     store_data;
    logic      reg_write;
    logic      mem_to_reg;
    logic      mem_read;
    logic      mem_write;
    logic      byte_en;
    logic      halfword_en;
    logic      word_en;

    integer  seed = 60;
    int      error_count = 0;
    int      check_count = 0;
    data_t   model [`MIPS_NUM_REGS];
    pc_t     next_pc = 32'h0040_0000;
    expect_t exp_q [$];
    string   name_q [$];
    expect_t cur_exp;
    string   cur_name;
    bit      cur_valid = 1'b0;

    logic [5:0] fn_list [10] = '{FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR,
                                 FN_NOR, FN_SLT, FN_SLL, FN_SRL, FN_SRA};
    logic [5:0] op_list [15] = '{OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI,
                                 OP_LW, OP_LH, OP_LB, OP_SW, OP_SH, OP_SB, OP_BEQ,
                                 6'h3f, 6'h02};
    // Together these raise every control output when not held in reset.
    logic [5:0] reset_ops [4] = '{OP_LW, OP_SH, OP_SB, OP_BEQ};

    id_ex_stage dut0 (.*);

    bind id_ex_stage id_ex_stage_chk u_chk (
        .i_clock      (i_clock),
        .rst_n        (rst_n),
        .reg_write    (reg_write),
        .mem_to_reg   (mem_to_reg),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .byte_en      (byte_en),
        .halfword_en  (halfword_en),
        .word_en      (word_en),
        .branch_taken (branch_taken)
    );

    always #20 i_clock = ~i_clock;

    initial begin
        repeat (10) @(posedge i_clock);
        rst_n <= 1'b1;
    end

    function automatic instr_t rtype_word(logic [5:0] fn, reg_addr_t rs, reg_addr_t rt,
                                          reg_addr_t rd, logic [4:0] sa);
        return {OP_RTYPE, rs, rt, rd, sa, fn};
    endfunction

    function automatic instr_t itype_word(logic [5:0] op, reg_addr_t rs, reg_addr_t rt,
                                          logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // Register zero reads zero, and a write-back in the same cycle is visible.
    function automatic data_t read_model(reg_addr_t r, logic wb_en, reg_addr_t wb_reg,
                                         data_t wb_data);
        if (r == '0)
            return '0;
        if (wb_en && (wb_reg == r))
            return wb_data;
        return model[r];
    endfunction

    function automatic expect_t predict_outputs(instr_t ins, pc_t ins_pc, data_t a, data_t b);
        expect_t    e;
        logic [5:0] op;
        data_t      sext;
        data_t      zext;
        logic [4:0] sa;
        op   = ins[31:26];
        sext = {{16{ins[15]}}, ins[15:0]};
        zext = {16'h0000, ins[15:0]};
        sa   = ins[10:6];
        e    = '0;
        case (op)
            OP_RTYPE: begin
                e.ctrl      = 7'b1000000;
                e.chk_alu   = 1'b1;
                e.chk_wreg  = 1'b1;
                e.write_reg = ins[15:11];
                case (ins[5:0])
                    FN_ADDU: e.alu_result = a + b;
                    FN_SUBU: e.alu_result = a - b;
                    FN_AND:  e.alu_result = a & b;
                    FN_OR:   e.alu_result = a | b;
                    FN_XOR:  e.alu_result = a ^ b;
                    FN_NOR:  e.alu_result = ~(a | b);
                    FN_SLT:  e.alu_result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    FN_SLL:  e.alu_result = b << sa;
                    FN_SRL:  e.alu_result = b >> sa;
                    FN_SRA:  e.alu_result = $signed(b) >>> sa;
                    default: e = '0;
                endcase
            end
            OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                e.ctrl      = 7'b1000000;
                e.chk_alu   = 1'b1;
                e.chk_wreg  = 1'b1;
                e.write_reg = ins[20:16];
                case (op)
                    OP_ADDIU: e.alu_result = a + sext;
                    OP_SLTI:  e.alu_result = ($signed(a) < $signed(sext)) ? 32'd1 : 32'd0;
                    OP_ANDI:  e.alu_result = a & zext;
                    OP_ORI:   e.alu_result = a | zext;
                    OP_XORI:  e.alu_result = a ^ zext;
                    default:  e.alu_result = {ins[15:0], 16'h0000};
                endcase
            end
            OP_LW, OP_LH, OP_LB: begin
                e.ctrl       = {4'b1110, op == OP_LB, op == OP_LH, op == OP_LW};
                e.alu_result = a + sext;
                e.chk_alu    = 1'b1;
                e.chk_wreg   = 1'b1;
                e.write_reg  = ins[20:16];
            end
            OP_SW, OP_SH, OP_SB: begin
                e.ctrl       = {4'b0001, op == OP_SB, op == OP_SH, op == OP_SW};
                e.alu_result = a + sext;
                e.chk_alu    = 1'b1;
                e.chk_store  = 1'b1;
                e.store_data = (op == OP_SB) ? {4{b[7:0]}} : (op == OP_SH) ? {2{b[15:0]}} : b;
            end
            OP_BEQ: begin
                e.branch_taken  = (a == b);
                e.branch_target = ins_pc + 32'd4 + (sext << 2);
                e.chk_target    = 1'b1;
            end
            default: ;
        endcase
        return e;
    endfunction

    task automatic check_field(string name, string field, logic [31:0] expected,
                               logic [31:0] actual);
        check_count++;
        assert (actual === expected)
        else begin
            error_count++;
            $display("Error %s: %s expected %h, actual %h", name, field, expected, actual);
        end
    endtask

    task automatic compare_outputs(expect_t e, string name);
        check_field(name, "controls", e.ctrl,
                    {reg_write, mem_to_reg, mem_read, mem_write, byte_en, halfword_en, word_en});
        check_field(name, "branch_taken", e.branch_taken, branch_taken);
        if (e.chk_alu)
            check_field(name, "alu_result", e.alu_result, alu_result);
        if (e.chk_target)
            check_field(name, "branch_target", e.branch_target, branch_target);
        if (e.chk_wreg)
            check_field(name, "write_reg", e.write_reg, write_reg);
        if (e.chk_store)
            check_field(name, "store_data", e.store_data, store_data);
    endtask

    // One instruction per rising edge, with an optional write-back in the same cycle.
    task automatic issue(string name, instr_t ins, logic wb_en, reg_addr_t wb_reg,
                         data_t wb_data);
        data_t a;
        data_t b;
        @(posedge i_clock);
        instr         <= ins;
        pc            <= next_pc;
        wb_reg_write  <= wb_en;
        wb_write_reg  <= wb_reg;
        wb_write_data <= wb_data;
        a = read_model(ins[25:21], wb_en, wb_reg, wb_data);
        b = read_model(ins[20:16], wb_en, wb_reg, wb_data);
        exp_q.push_back(predict_outputs(ins, next_pc, a, b));
        name_q.push_back(name);
        if (wb_en && (wb_reg != '0))
            model[wb_reg] = wb_data;
        next_pc = next_pc + 32'd4;
    endtask

    // An instruction queued at one edge is captured at the next and checked after it.
    always @(negedge i_clock) begin
        if (cur_valid)
            compare_outputs(cur_exp, cur_name);
        cur_valid = 1'b0;
        if (exp_q.size() > 0) begin
            cur_exp   = exp_q.pop_front();
            cur_name  = name_q.pop_front();
            cur_valid = 1'b1;
        end
    end

    initial begin
        int        wait_count;
        int        sel;
        data_t     rnd;
        data_t     wb_rnd;
        instr_t    ins;
        instr         = BUBBLE;
        pc            = '0;
        wb_reg_write  = 1'b0;
        wb_write_reg  = '0;
        wb_write_data = '0;
        for (int i = 0; i < `MIPS_NUM_REGS; i++)
            model[i] = '0;

        wait_count = 0;
        while (!rst_n && (wait_count < RESET_TIMEOUT)) begin
            @(posedge i_clock);
            instr <= itype_word(reset_ops[wait_count % 4], 5'd0, 5'd0, 16'h0001);
            @(negedge i_clock);
            check_field("reset", "controls", 32'd0, {reg_write, mem_to_reg, mem_read,
                        mem_write, byte_en, halfword_en, word_en, branch_taken});
            wait_count++;
        end

        if (!rst_n) begin
            error_count++;
            $display("Reset was never released within the time limit.");
        end else begin
            for (int i = 0; i < `MIPS_NUM_REGS; i++)
                issue("reset registers", rtype_word(FN_OR, i, 5'd0, 5'd1, 5'd0), 0, 0, 0);
            for (int i = 1; i < `MIPS_NUM_REGS; i++)
                issue("operand load", BUBBLE, 1'b1, i, $random(seed));

            for (int n = 0; n < NUM_RANDOM; n++) begin
                sel    = $unsigned($random(seed)) % 25;
                rnd    = $random(seed);
                wb_rnd = $random(seed);
                if (sel < 10) begin
                    ins = rtype_word(fn_list[sel], rnd[4:0], rnd[9:5], rnd[14:10], rnd[19:15]);
                    issue("random R-type", ins, wb_rnd[0], wb_rnd[5:1], $random(seed));
                end else begin
                    ins = itype_word(op_list[sel - 10], rnd[4:0], rnd[9:5], rnd[31:16]);
                    issue("random I-type", ins, wb_rnd[0], wb_rnd[5:1], $random(seed));
                end
            end

            issue("write-through", rtype_word(FN_ADDU, 5'd5, 5'd6, 5'd3, 5'd0),
                  1'b1, 5'd5, 32'h1234_5678);
            issue("write-through", rtype_word(FN_SUBU, 5'd6, 5'd5, 5'd4, 5'd0),
                  1'b1, 5'd6, 32'h0000_0042);
            issue("zero write", BUBBLE, 1'b1, 5'd0, 32'hdead_beef);
            issue("zero read", rtype_word(FN_OR, 5'd0, 5'd0, 5'd2, 5'd0),
                  1'b1, 5'd0, 32'hcafe_f00d);
            issue("operand setup", BUBBLE, 1'b1, 5'd7, 32'h0000_abcd);
            issue("operand setup", BUBBLE, 1'b1, 5'd8, 32'h0000_abcd);
            issue("operand setup", BUBBLE, 1'b1, 5'd10, 32'h8899_aabb);
            issue("beq forward", itype_word(OP_BEQ, 5'd7, 5'd8, 16'h0010), 0, 0, 0);
            issue("beq backward", itype_word(OP_BEQ, 5'd8, 5'd7, 16'hfff0), 0, 0, 0);
            issue("beq not taken", itype_word(OP_BEQ, 5'd7, 5'd10, 16'h0004), 0, 0, 0);
            issue("store byte", itype_word(OP_SB, 5'd7, 5'd10, 16'hfffc), 0, 0, 0);
            issue("store half", itype_word(OP_SH, 5'd7, 5'd10, 16'h0002), 0, 0, 0);
            issue("store word", itype_word(OP_SW, 5'd7, 5'd10, 16'h0008), 0, 0, 0);
            issue("load byte", itype_word(OP_LB, 5'd10, 5'd11, 16'h8001), 0, 0, 0);
            issue("load half", itype_word(OP_LH, 5'd10, 5'd11, 16'h0006), 0, 0, 0);
            issue("load word", itype_word(OP_LW, 5'd10, 5'd11, 16'hff00), 0, 0, 0);
            issue("lui", itype_word(OP_LUI, 5'd0, 5'd11, 16'h8001), 0, 0, 0);
            issue("andi zero extend", itype_word(OP_ANDI, 5'd10, 5'd12, 16'hf0f0), 0, 0, 0);
            issue("addiu sign extend", itype_word(OP_ADDIU, 5'd10, 5'd12, 16'h8000), 0, 0, 0);
            issue("unknown opcode", BUBBLE, 1'b0, 5'd0, 32'd0);
            issue("unknown function", rtype_word(6'h3f, 5'd7, 5'd8, 5'd9, 5'd0), 0, 0, 0);
            issue("final bubble", BUBBLE, 1'b0, 5'd0, 32'd0);

            wait_count = 0;
            while (((exp_q.size() > 0) || cur_valid) && (wait_count < DRAIN_TIMEOUT)) begin
                @(posedge i_clock);
                wait_count++;
            end
            if ((exp_q.size() > 0) || cur_valid) begin
                error_count++;
                $display("The expected results were not all compared within the time limit.");
            end
        end

        error_count += dut0.u_chk.fail_count;
        $display("Checks: %0d, errors: %0d, checker failures: %0d",
                 check_count, error_count, dut0.u_chk.fail_count);
        if (error_count == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/ex_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module ex_unit
    import mips_pkg::*;
(
    input  logic      ex_mem_write,
    input  logic      ex_branch,
    input  logic      ex_alu_src,
    input  logic      ex_reg_dest,
    input  alu_op_t   ex_alu_op,
    input  pc_t       ex_pc,
    input  data_t     ex_data_a,
    input  data_t     ex_data_b,
    input  imm_t      ex_immediate,
    input  data_t     ex_shamt,
    input  reg_addr_t ex_rt,
    input  reg_addr_t ex_rd,
    input  logic      ex_byte_en,
    input  logic      ex_halfword_en,
    input  logic      ex_word_en,
    output data_t     alu_result,
    output logic      branch_taken,
    output pc_t       branch_target,
    output reg_addr_t write_reg,
    output data_t     store_data
);

    data_t operand_b;
    logic  [4:0] shift_amount;

    assign operand_b    = ex_alu_src ? data_t'(ex_immediate) : ex_data_b;
    assign shift_amount = ex_shamt[4:0]; // Upper bits are always zero.

    always_comb begin
        case (ex_alu_op)
            ALU_ADD: alu_result = ex_data_a + operand_b;
            ALU_SUB: alu_result = ex_data_a - operand_b;
            ALU_AND: alu_result = ex_data_a & operand_b;
            ALU_OR:  alu_result = ex_data_a | operand_b;
            ALU_XOR: alu_result = ex_data_a ^ operand_b;
            ALU_NOR: alu_result = ~(ex_data_a | operand_b);
            ALU_SLT: alu_result = data_t'($signed(ex_data_a) < $signed(operand_b));
            ALU_SLL: alu_result = operand_b << shift_amount;
            ALU_SRL: alu_result = operand_b >> shift_amount;
            ALU_SRA: alu_result = data_t'($signed(operand_b) >>> shift_amount);
            ALU_LUI: alu_result = {ex_immediate[15:0], 16'b0};
            default: alu_result = '0;
        endcase
    end

    assign write_reg = ex_reg_dest ? ex_rd : ex_rt;

    // BEQ compares the register operands directly.
    assign branch_taken  = ex_branch && (ex_data_a == ex_data_b);
    assign branch_target = ex_pc + pc_t'(4) + pc_t'({ex_immediate[29:0], 2'b00});

    // Narrow stores repeat the lane so any byte address finds its data.
    always_comb begin
        if (ex_mem_write && ex_byte_en)
            store_data = {4{ex_data_b[7:0]}};
        else if (ex_mem_write && ex_halfword_en)
            store_data = {2{ex_data_b[15:0]}};
        else if (ex_mem_write && ex_word_en)
            store_data = ex_data_b;
        else
            store_data = '0; // Not a store, so the bus stays quiet.
    end

endmodule

`default_nettype wire

/* verilog/id_ex_reg.sv */
`timescale 1ns/1ns
`default_nettype none

module id_ex_reg
    import mips_pkg::*;
(
    input  logic      i_clock,
    input  logic      rst_n,
    input  logic      id_reg_write,
    input  logic      id_mem_to_reg,
    input  logic      id_mem_read,
    input  logic      id_mem_write,
    input  logic      id_branch,
    input  logic      id_alu_src,
    input  logic      id_reg_dest,
    input  alu_op_t   id_alu_op,
    input  pc_t       id_pc,
    input  data_t     id_data_a,
    input  data_t     id_data_b,
    input  imm_t      id_immediate,
    input  data_t     id_shamt,
    input  reg_addr_t id_rt,
    input  reg_addr_t id_rd,
    input  logic      id_byte_en,
    input  logic      id_halfword_en,
    input  logic      id_word_en,
    output logic      ex_reg_write,
    output logic      ex_mem_to_reg,
    output logic      ex_mem_read,
    output logic      ex_mem_write,
    output logic      ex_branch,
    output logic      ex_alu_src,
    output logic      ex_reg_dest,
    output alu_op_t   ex_alu_op,
    output pc_t       ex_pc,
    output data_t     ex_data_a,
    output data_t     ex_data_b,
    output imm_t      ex_immediate,
    output data_t     ex_shamt,
    output reg_addr_t ex_rt,
    output reg_addr_t ex_rd,
    output logic      ex_byte_en,
    output logic      ex_halfword_en,
    output logic      ex_word_en
);

    // Clearing the control bits turns the slot into a bubble.
    always_ff @(posedge i_clock or negedge rst_n) begin
        if (!rst_n) begin
            ex_reg_write   <= 1'b0;
            ex_mem_to_reg  <= 1'b0;
            ex_mem_read    <= 1'b0;
            ex_mem_write   <= 1'b0;
            ex_branch      <= 1'b0;
            ex_alu_src     <= 1'b0;
            ex_reg_dest    <= 1'b0;
            ex_byte_en     <= 1'b0;
            ex_halfword_en <= 1'b0;
            ex_word_en     <= 1'b0;
        end else begin
            ex_reg_write   <= id_reg_write;
            ex_mem_to_reg  <= id_mem_to_reg;
            ex_mem_read    <= id_mem_read;
            ex_mem_write   <= id_mem_write;
            ex_branch      <= id_branch;
            ex_alu_src     <= id_alu_src;
            ex_reg_dest    <= id_reg_dest;
            ex_byte_en     <= id_byte_en;
            ex_halfword_en <= id_halfword_en;
            ex_word_en     <= id_word_en;
        end
    end

    always_ff @(posedge i_clock) begin
        ex_alu_op    <= id_alu_op;
        ex_pc        <= id_pc;
        ex_data_a    <= id_data_a;
        ex_data_b    <= id_data_b;
        ex_immediate <= id_immediate;
        ex_shamt     <= id_shamt;
        ex_rt        <= id_rt;
        ex_rd        <= id_rd;
    end

endmodule

`default_nettype wire

/* verilog/id_ex_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module id_ex_stage
    import mips_pkg::*;
(
    input  logic      i_clock,
    input  logic      rst_n,
    input  instr_t    instr,
    input  pc_t       pc,
    input  logic      wb_reg_write,
    input  reg_addr_t wb_write_reg,
    input  data_t     wb_write_data,
    output data_t     alu_result,
    output logic      branch_taken,
    output pc_t       branch_target,
    output reg_addr_t write_reg,
    output data_t     store_data,
    output logic      reg_write,
    output logic      mem_to_reg,
    output logic      mem_read,
    output logic      mem_write,
    output logic      byte_en,
    output logic      halfword_en,
    output logic      word_en
);

    reg_addr_t id_rs;
    reg_addr_t id_rt;
    reg_addr_t id_rd;
    logic      id_reg_write;
    logic      id_mem_to_reg;
    logic      id_mem_read;
    logic      id_mem_write;
    logic      id_branch;
    logic      id_alu_src;
    logic      id_reg_dest;
    logic      id_byte_en;
    logic      id_halfword_en;
    logic      id_word_en;
    alu_op_t   id_alu_op;
    imm_t      id_immediate;
    data_t     id_shamt;
    data_t     id_data_a;
    data_t     id_data_b;

    logic      ex_branch;
    logic      ex_alu_src;
    logic      ex_reg_dest;
    alu_op_t   ex_alu_op;
    pc_t       ex_pc;
    data_t     ex_data_a;
    data_t     ex_data_b;
    imm_t      ex_immediate;
    data_t     ex_shamt;
    reg_addr_t ex_rt;
    reg_addr_t ex_rd;

    instr_decoder u_decoder (
        .instr       (instr),
        .rs          (id_rs),
        .rt          (id_rt),
        .reg_write   (id_reg_write),
        .mem_to_reg  (id_mem_to_reg),
        .mem_read    (id_mem_read),
        .mem_write   (id_mem_write),
        .branch      (id_branch),
        .alu_src     (id_alu_src),
        .reg_dest    (id_reg_dest),
        .byte_en     (id_byte_en),
        .halfword_en (id_halfword_en),
        .word_en     (id_word_en),
        .alu_op      (id_alu_op),
        .immediate   (id_immediate),
        .shamt       (id_shamt),
        .rd          (id_rd)
    );

    register_file u_regfile (
        .i_clock     (i_clock),
        .rst_n       (rst_n),
        .read_addr_a (id_rs),
        .read_addr_b (id_rt),
        .read_data_a (id_data_a),
        .read_data_b (id_data_b),
        .write_en    (wb_reg_write),
        .write_addr  (wb_write_reg),
        .write_data  (wb_write_data)
    );

    id_ex_reg u_id_ex (
        .i_clock        (i_clock),
        .rst_n          (rst_n),
        .id_reg_write   (id_reg_write),
        .id_mem_to_reg  (id_mem_to_reg),
        .id_mem_read    (id_mem_read),
        .id_mem_write   (id_mem_write),
        .id_branch      (id_branch),
        .id_alu_src     (id_alu_src),
        .id_reg_dest    (id_reg_dest),
        .id_alu_op      (id_alu_op),
        .id_pc          (pc),
        .id_data_a      (id_data_a),
        .id_data_b      (id_data_b),
        .id_immediate   (id_immediate),
        .id_shamt       (id_shamt),
        .id_rt          (id_rt),
        .id_rd          (id_rd),
        .id_byte_en     (id_byte_en),
        .id_halfword_en (id_halfword_en),
        .id_word_en     (id_word_en),
        .ex_reg_write   (reg_write),
        .ex_mem_to_reg  (mem_to_reg),
        .ex_mem_read    (mem_read),
        .ex_mem_write   (mem_write),
        .ex_branch      (ex_branch),
        .ex_alu_src     (ex_alu_src),
        .ex_reg_dest    (ex_reg_dest),
        .ex_alu_op      (ex_alu_op),
        .ex_pc          (ex_pc),
        .ex_data_a      (ex_data_a),
        .ex_data_b      (ex_data_b),
        .ex_immediate   (ex_immediate),
        .ex_shamt       (ex_shamt),
        .ex_rt          (ex_rt),
        .ex_rd          (ex_rd),
        .ex_byte_en     (byte_en),
        .ex_halfword_en (halfword_en),
        .ex_word_en     (word_en)
    );

    ex_unit u_ex (
        .ex_mem_write   (mem_write),
        .ex_branch      (ex_branch),
        .ex_alu_src     (ex_alu_src),
        .ex_reg_dest    (ex_reg_dest),
        .ex_alu_op      (ex_alu_op),
        .ex_pc          (ex_pc),
        .ex_data_a      (ex_data_a),
        .ex_data_b      (ex_data_b),
        .ex_immediate   (ex_immediate),
        .ex_shamt       (ex_shamt),
        .ex_rt          (ex_rt),
        .ex_rd          (ex_rd),
        .ex_byte_en     (byte_en),
        .ex_halfword_en (halfword_en),
        .ex_word_en     (word_en),
        .alu_result     (alu_result),
        .branch_taken   (branch_taken),
        .branch_target  (branch_target),
        .write_reg      (write_reg),
        .store_data     (store_data)
    );

endmodule

`default_nettype wire

/* verilog/instr_decoder.sv */
`timescale 1ns/1ns
`default_nettype none

module instr_decoder
    import mips_pkg::*;
(
    input  instr_t    instr,
    output reg_addr_t rs,
    output reg_addr_t rt,
    output logic      reg_write,
    output logic      mem_to_reg,
    output logic      mem_read,
    output logic      mem_write,
    output logic      branch,
    output logic      alu_src,
    output logic      reg_dest,
    output logic      byte_en,
    output logic      halfword_en,
    output logic      word_en,
    output alu_op_t   alu_op,
    output imm_t      immediate,
    output data_t     shamt,
    output reg_addr_t rd
);

    logic [5:0] opcode;
    logic [5:0] funct;
    logic       zero_ext;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];
    assign rs     = instr[25:21];
    assign rt     = instr[20:16];
    assign rd     = instr[15:11];
    assign shamt  = data_t'(instr[10:6]); // Unsigned cast zero-extends.

    assign immediate = zero_ext ? {16'b0, instr[15:0]} : {{16{instr[15]}}, instr[15:0]};

    always_comb begin
        reg_write   = 1'b0;
        mem_to_reg  = 1'b0;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        branch      = 1'b0;
        alu_src     = 1'b0;
        reg_dest    = 1'b0;
        byte_en     = 1'b0;
        halfword_en = 1'b0;
        word_en     = 1'b0;
        zero_ext    = 1'b0;
        alu_op      = ALU_ADD;
        case (opcode)
            OP_RTYPE: begin
                reg_write = 1'b1;
                reg_dest  = 1'b1;
                case (funct)
                    FN_ADDU: alu_op = ALU_ADD;
                    FN_SUBU: alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_XOR:  alu_op = ALU_XOR;
                    FN_NOR:  alu_op = ALU_NOR;
                    FN_SLT:  alu_op = ALU_SLT;
                    FN_SLL:  alu_op = ALU_SLL;
                    FN_SRL:  alu_op = ALU_SRL;
                    FN_SRA:  alu_op = ALU_SRA;
                    default: begin
                        reg_write = 1'b0; // Unknown function code is a bubble.
                        reg_dest  = 1'b0;
                    end
                endcase
            end
            OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                reg_write = 1'b1;
                alu_src   = 1'b1;
                case (opcode)
                    OP_SLTI: alu_op = ALU_SLT;
                    OP_ANDI: alu_op = ALU_AND;
                    OP_ORI:  alu_op = ALU_OR;
                    OP_XORI: alu_op = ALU_XOR;
                    OP_LUI:  alu_op = ALU_LUI;
                    default: alu_op = ALU_ADD;
                endcase
                zero_ext = (opcode == OP_ANDI) || (opcode == OP_ORI) || (opcode == OP_XORI);
            end
            OP_LW, OP_LH, OP_LB: begin
                reg_write   = 1'b1;
                mem_to_reg  = 1'b1;
                mem_read    = 1'b1;
                alu_src     = 1'b1; // Address is base plus offset.
                word_en     = (opcode == OP_LW);
                halfword_en = (opcode == OP_LH);
                byte_en     = (opcode == OP_LB);
            end
            OP_SW, OP_SH, OP_SB: begin
                mem_write   = 1'b1;
                alu_src     = 1'b1;
                word_en     = (opcode == OP_SW);
                halfword_en = (opcode == OP_SH);
                byte_en     = (opcode == OP_SB);
            end
            OP_BEQ: begin
                branch = 1'b1;
                alu_op = ALU_SUB;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* verilog/mips_config.svh */
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

// Datapath word width.
`define MIPS_NB_DATA    32

// Instruction address width.
`define MIPS_NB_PC      32

`define MIPS_NB_REG     5

// Width of the immediate after sign or zero extension.
`define MIPS_NB_IMM     32

`define MIPS_NB_ALU_OP  6
`define MIPS_NB_INSTR   32

// Architectural register count, register zero included.
`define MIPS_NUM_REGS   32

`endif

/* verilog/mips_pkg.sv */
`default_nettype none

`include "mips_config.svh"

package mips_pkg;

    typedef logic [`MIPS_NB_DATA-1:0]   data_t;
    typedef logic [`MIPS_NB_PC-1:0]     pc_t;
    typedef logic [`MIPS_NB_REG-1:0]    reg_addr_t;
    typedef logic [`MIPS_NB_IMM-1:0]    imm_t;
    typedef logic [`MIPS_NB_ALU_OP-1:0] alu_op_t;
    typedef logic [`MIPS_NB_INSTR-1:0]  instr_t;

    localparam logic [5:0] OP_RTYPE = 6'h00; // All R-type share opcode zero.
    localparam logic [5:0] OP_BEQ   = 6'h04;
    localparam logic [5:0] OP_ADDIU = 6'h09;
    localparam logic [5:0] OP_SLTI  = 6'h0a;
    localparam logic [5:0] OP_ANDI  = 6'h0c;
    localparam logic [5:0] OP_ORI   = 6'h0d;
    localparam logic [5:0] OP_XORI  = 6'h0e;
    localparam logic [5:0] OP_LUI   = 6'h0f;
    localparam logic [5:0] OP_LB    = 6'h20;
    localparam logic [5:0] OP_LH    = 6'h21;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SB    = 6'h28;
    localparam logic [5:0] OP_SH    = 6'h29;
    localparam logic [5:0] OP_SW    = 6'h2b;

    localparam logic [5:0] FN_SLL   = 6'h00;
    localparam logic [5:0] FN_SRL   = 6'h02;
    localparam logic [5:0] FN_SRA   = 6'h03;
    localparam logic [5:0] FN_ADDU  = 6'h21;
    localparam logic [5:0] FN_SUBU  = 6'h23;
    localparam logic [5:0] FN_AND   = 6'h24;
    localparam logic [5:0] FN_OR    = 6'h25;
    localparam logic [5:0] FN_XOR   = 6'h26;
    localparam logic [5:0] FN_NOR   = 6'h27;
    localparam logic [5:0] FN_SLT   = 6'h2a;

    localparam alu_op_t ALU_ADD = 'd0;
    localparam alu_op_t ALU_SUB = 'd1;
    localparam alu_op_t ALU_AND = 'd2;
    localparam alu_op_t ALU_OR  = 'd3;
    localparam alu_op_t ALU_XOR = 'd4;
    localparam alu_op_t ALU_NOR = 'd5;
    localparam alu_op_t ALU_SLT = 'd6;
    localparam alu_op_t ALU_SLL = 'd7;
    localparam alu_op_t ALU_SRL = 'd8;
    localparam alu_op_t ALU_SRA = 'd9;
    localparam alu_op_t ALU_LUI = 'd10;

endpackage

`default_nettype wire

/* verilog/register_file.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mips_config.svh"

module register_file
    import mips_pkg::*;
(
    input  logic      i_clock,
    input  logic      rst_n,
    input  reg_addr_t read_addr_a,
    input  reg_addr_t read_addr_b,
    output data_t     read_data_a,
    output data_t     read_data_b,
    input  logic      write_en,
    input  reg_addr_t write_addr,
    input  data_t     write_data
);

    data_t regs [`MIPS_NUM_REGS];

    always_ff @(posedge i_clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `MIPS_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en && (write_addr != '0)) begin
            regs[write_addr] <= write_data; // Register zero is never written.
        end
    end

    // A write in the same cycle is forwarded so decode sees the new value.
    always_comb begin
        if (read_addr_a == '0)
            read_data_a = '0;
        else if (write_en && (write_addr == read_addr_a))
            read_data_a = write_data;
        else
            read_data_a = regs[read_addr_a];
    end

    always_comb begin
        if (read_addr_b == '0)
            read_data_b = '0;
        else if (write_en && (write_addr == read_addr_b))
            read_data_b = write_data;
        else
            read_data_b = regs[read_addr_b];
    end

endmodule

`default_nettype wire
